// File: Bender.yml
package:
  name: riscv_system

sources:
  - include_dirs:
      - source
    files:
      - source/riscv_isa_pkg.sv
      - source/pipeline_pkg.sv
      - source/stage_reg.sv
      - source/reg_file.sv
      - source/decode_unit.sv
      - source/execute_unit.sv
      - source/fetch_unit.sv
      - source/unified_memory.sv
      - source/riscv_system.sv
  - target: test
    include_dirs:
      - source
    files:
      - testbench/riscv_system_checker.sv
      - testbench/riscv_system_tb.sv

// File: source/decode_unit.sv
`timescale 1ns/1ns

module decode_unit (
  input  logic                      clk,
  input  logic                      rst,
  input  pipeline_pkg::fd_payload_t fd,
  input  pipeline_pkg::de_payload_t de_q,
  input  pipeline_pkg::mw_payload_t mw,
  output pipeline_pkg::de_payload_t de_next,
  output logic                      stall,
  output riscv_isa_pkg::word_t      wb_data
);

  import riscv_isa_pkg::*;
  import pipeline_pkg::*;

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  reg_idx_t   rd;
  reg_idx_t   rs1;
  reg_idx_t   rs2;
  word_t      imm;
  word_t      rf_rs1;
  word_t      rf_rs2;
  word_t      rs1_val;
  word_t      rs2_val;
  alu_op_t    alu_op;
  logic       reg_write;
  logic       mem_read;
  logic       mem_write;
  logic       branch;
  logic       jal;
  logic       jalr;
  logic       halt;
  logic       uses_rs1;
  logic       uses_rs2;

  assign opcode = fd.inst[6:0];
  assign rd     = fd.inst[11:7];
  assign funct3 = fd.inst[14:12];
  assign rs1    = fd.inst[19:15];
  assign rs2    = fd.inst[24:20];
  assign funct7 = fd.inst[31:25];

  always_comb begin
    case (opcode)
      op_store:  imm = {{20{fd.inst[31]}}, fd.inst[31:25], fd.inst[11:7]};
      op_branch: imm = {{20{fd.inst[31]}}, fd.inst[7], fd.inst[30:25], fd.inst[11:8], 1'b0};
      op_jal:    imm = {{12{fd.inst[31]}}, fd.inst[19:12], fd.inst[20], fd.inst[30:21], 1'b0};
      op_lui, op_auipc: imm = {fd.inst[31:12], 12'b0};
      // I-type covers loads, jalr and reg-imm
      default:   imm = {{20{fd.inst[31]}}, fd.inst[31:20]};
    endcase
  end

  always_comb begin
    reg_write = 1'b0;
    mem_read  = 1'b0;
    mem_write = 1'b0;
    branch    = 1'b0;
    jal       = 1'b0;
    jalr      = 1'b0;
    halt      = 1'b0;
    case (opcode)
      op_reg_reg, op_reg_imm, op_lui, op_auipc: reg_write = 1'b1;
      op_load: begin
        reg_write = 1'b1;
        mem_read  = 1'b1;
      end
      op_store:  mem_write = 1'b1;
      op_branch: branch = 1'b1;
      op_jal: begin
        reg_write = 1'b1;
        jal       = 1'b1;
      end
      op_jalr: begin
        reg_write = 1'b1;
        jalr      = 1'b1;
      end
      // only the exact ECALL word stops the core
      op_system: halt = (fd.inst == 32'h0000_0073);
      default: ;
    endcase
  end

  // funct7 bit 5 picks sub and sra; reg-imm has no subtract form
  always_comb begin
    alu_op = alu_add;
    if ((opcode == op_reg_reg) || (opcode == op_reg_imm)) begin
      case (funct3)
        3'b000: alu_op = ((opcode == op_reg_reg) && funct7[5]) ? alu_sub : alu_add;
        3'b001: alu_op = alu_sll;
        3'b010: alu_op = alu_slt;
        3'b011: alu_op = alu_sltu;
        3'b100: alu_op = alu_xor;
        3'b101: alu_op = funct7[5] ? alu_sra : alu_srl;
        3'b110: alu_op = alu_or;
        default: alu_op = alu_and;
      endcase
    end
  end

  assign uses_rs1 = !((opcode == op_lui) || (opcode == op_auipc) || (opcode == op_jal));
  assign uses_rs2 = (opcode == op_reg_reg) || (opcode == op_branch) || (opcode == op_store);

  reg_file i_reg_file (
    .clk      (clk),
    .rst      (rst),
    .we       (mw.reg_write),
    .rd       (mw.rd),
    .rd_data  (wb_data),
    .rs1      (rs1),
    .rs2      (rs2),
    .rs1_data (rf_rs1),
    .rs2_data (rf_rs2)
  );

  assign wb_data = mw.mem_read ? mw.load_data : mw.alu_result;

  // writeback lands this cycle, so hand it straight to decode
  assign rs1_val = (mw.reg_write && (mw.rd != '0) && (mw.rd == rs1)) ? wb_data : rf_rs1;
  assign rs2_val = (mw.reg_write && (mw.rd != '0) && (mw.rd == rs2)) ? wb_data : rf_rs2;

  // load data is not ready for M-to-E forwarding, store rs2 included
  assign stall = de_q.mem_read && (de_q.rd != '0) &&
                 ((uses_rs1 && (de_q.rd == rs1)) || (uses_rs2 && (de_q.rd == rs2)));

  assign de_next = '{
    pc:        fd.pc,
    inst:      fd.inst,
    rs1_data:  rs1_val,
    rs2_data:  rs2_val,
    imm:       imm,
    rd:        rd,
    rs1:       rs1,
    rs2:       rs2,
    alu_op:    alu_op,
    reg_write: reg_write,
    mem_read:  mem_read,
    mem_write: mem_write,
    branch:    branch,
    jal:       jal,
    jalr:      jalr,
    halt:      halt
  };

endmodule

// File: source/execute_unit.sv
`timescale 1ns/1ns

module execute_unit (
  input  pipeline_pkg::de_payload_t de,
  input  pipeline_pkg::em_payload_t em,
  input  pipeline_pkg::mw_payload_t mw,
  input  riscv_isa_pkg::word_t      wb_data,
  output pipeline_pkg::em_payload_t em_next,
  output logic                      redirect,
  output riscv_isa_pkg::word_t      redirect_pc
);

  import riscv_isa_pkg::*;
  import pipeline_pkg::*;

  word_t      op_a;
  word_t      rs2_fwd;
  word_t      op_b;
  word_t      alu_out;
  word_t      result;
  word_t      jalr_sum;
  logic [6:0] opcode;
  logic       taken;
  logic       eq;
  logic       lt_s;
  logic       lt_u;

  // M is younger than W, so it wins
  function automatic word_t forward(reg_idx_t idx, word_t reg_val);
    if (em.reg_write && (em.rd != '0) && (em.rd == idx)) begin
      return em.alu_result;
    end else if (mw.reg_write && (mw.rd != '0) && (mw.rd == idx)) begin
      return wb_data;
    end
    return reg_val;
  endfunction

  always_comb begin
    op_a    = forward(de.rs1, de.rs1_data);
    rs2_fwd = forward(de.rs2, de.rs2_data);
  end

  assign opcode = de.inst[6:0];
  assign op_b   = ((opcode == op_reg_reg) || (opcode == op_branch)) ? rs2_fwd : de.imm;

  always_comb begin
    case (de.alu_op)
      alu_add:  alu_out = op_a + op_b;
      alu_sub:  alu_out = op_a - op_b;
      alu_and:  alu_out = op_a & op_b;
      alu_or:   alu_out = op_a | op_b;
      alu_xor:  alu_out = op_a ^ op_b;
      alu_sll:  alu_out = op_a << op_b[4:0];
      alu_srl:  alu_out = op_a >> op_b[4:0];
      alu_sra:  alu_out = $signed(op_a) >>> op_b[4:0];
      alu_slt:  alu_out = word_t'($signed(op_a) < $signed(op_b));
      alu_sltu: alu_out = word_t'(op_a < op_b);
      default:  alu_out = '0;
    endcase
  end

  // upper immediates and links bypass the ALU result
  always_comb begin
    case (opcode)
      op_lui:         result = de.imm;
      op_auipc:       result = de.pc + de.imm;
      op_jal, op_jalr: result = de.pc + 32'd4;
      default:        result = alu_out;
    endcase
  end

  assign eq   = (op_a == rs2_fwd);
  assign lt_s = ($signed(op_a) < $signed(rs2_fwd));
  assign lt_u = (op_a < rs2_fwd);

  always_comb begin
    case (de.inst[14:12])
      f3_beq:  taken = eq;
      f3_bne:  taken = !eq;
      f3_blt:  taken = lt_s;
      f3_bge:  taken = !lt_s;
      f3_bltu: taken = lt_u;
      f3_bgeu: taken = !lt_u;
      default: taken = 1'b0;
    endcase
  end

  assign jalr_sum    = op_a + de.imm;
  assign redirect    = (de.branch && taken) || de.jal || de.jalr;
  assign redirect_pc = de.jalr ? {jalr_sum[31:1], 1'b0} : (de.pc + de.imm);

  assign em_next = '{
    pc:         de.pc,
    inst:       de.inst,
    alu_result: result,
    store_data: rs2_fwd,
    rd:         de.rd,
    reg_write:  de.reg_write,
    mem_read:   de.mem_read,
    mem_write:  de.mem_write,
    halt:       de.halt
  };

endmodule

// File: source/fetch_unit.sv
`timescale 1ns/1ns
`include "riscv_config.svh"

module fetch_unit (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 stall,
  input  logic                 halt,
  input  logic                 redirect,
  input  riscv_isa_pkg::word_t redirect_pc,
  output riscv_isa_pkg::word_t pc
);

  import riscv_isa_pkg::*;

  word_t pc_q;

  // halt freezes fetch even if a stale jump keeps redirecting
  always_ff @(posedge clk) begin
    if (rst) begin
      pc_q <= `RV_RESET_PC;
    end else if (halt) begin
      pc_q <= pc_q;
    end else if (redirect) begin
      pc_q <= redirect_pc;
    end else if (!stall) begin
      pc_q <= pc_q + 32'd4;
    end
  end

  assign pc = pc_q;

endmodule

// File: source/pipeline_pkg.sv
`include "riscv_config.svh"

package pipeline_pkg;

  import riscv_isa_pkg::*;

  typedef struct packed {
    word_t pc;
    word_t inst;
  } fd_payload_t;

  typedef struct packed {
    word_t    pc;
    word_t    inst;
    word_t    rs1_data;
    word_t    rs2_data;
    word_t    imm;
    reg_idx_t rd;
    reg_idx_t rs1;
    reg_idx_t rs2;
    alu_op_t  alu_op;
    logic     reg_write;
    logic     mem_read;
    logic     mem_write;
    logic     branch;
    logic     jal;
    logic     jalr;
    logic     halt;
  } de_payload_t;

  typedef struct packed {
    word_t    pc;
    word_t    inst;
    word_t    alu_result;
    word_t    store_data;
    reg_idx_t rd;
    logic     reg_write;
    logic     mem_read;
    logic     mem_write;
    logic     halt;
  } em_payload_t;

  typedef struct packed {
    word_t    pc;
    word_t    inst;
    word_t    alu_result;
    word_t    load_data;
    reg_idx_t rd;
    logic     reg_write;
    logic     mem_read;
    logic     halt;
  } mw_payload_t;

  // bubbles carry pc 0 and a nop so the trace reads as empty
  localparam fd_payload_t fd_bubble = '{pc: '0, inst: `RV_NOP};
  localparam de_payload_t de_bubble = '{inst: `RV_NOP, alu_op: alu_add, default: '0};
  localparam em_payload_t em_bubble = '{inst: `RV_NOP, default: '0};
  localparam mw_payload_t mw_bubble = '{inst: `RV_NOP, default: '0};

endpackage

// File: source/reg_file.sv
`timescale 1ns/1ns
`include "riscv_config.svh"

module reg_file (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    we,
  input  riscv_isa_pkg::reg_idx_t rd,
  input  riscv_isa_pkg::word_t    rd_data,
  input  riscv_isa_pkg::reg_idx_t rs1,
  input  riscv_isa_pkg::reg_idx_t rs2,
  output riscv_isa_pkg::word_t    rs1_data,
  output riscv_isa_pkg::word_t    rs2_data
);

  import riscv_isa_pkg::*;

  word_t regs [`RV_NUM_REGS];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < `RV_NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (we && (rd != '0)) begin
      regs[rd] <= rd_data;
    end
  end

  // x0 is hardwired
  assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
  assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

endmodule

// File: source/riscv_config.svh
`ifndef RISCV_CONFIG_SVH
`define RISCV_CONFIG_SVH

// data and address width
`define RV_XLEN 32

// architectural register count
`define RV_NUM_REGS 32

// unified memory depth in 32-bit words
`define RV_MEM_WORDS 1024

// first fetch address after reset
`define RV_RESET_PC 32'h0000_0000

// addi x0,x0,0 fills every pipeline bubble
`define RV_NOP 32'h0000_0013

`endif

// File: source/riscv_isa_pkg.sv
`include "riscv_config.svh"

package riscv_isa_pkg;

  typedef logic [`RV_XLEN-1:0] word_t;
  typedef logic [$clog2(`RV_NUM_REGS)-1:0] reg_idx_t;

  // major opcodes of the supported RV32I subset
  typedef enum logic [6:0] {
    op_load    = 7'b00_000_11,
    op_store   = 7'b01_000_11,
    op_branch  = 7'b11_000_11,
    op_jalr    = 7'b11_001_11,
    op_jal     = 7'b11_011_11,
    op_reg_imm = 7'b00_100_11,
    op_reg_reg = 7'b01_100_11,
    op_system  = 7'b11_100_11,
    op_auipc   = 7'b00_101_11,
    op_lui     = 7'b01_101_11
  } opcode_t;

  typedef enum logic [3:0] {
    alu_add,
    alu_sub,
    alu_and,
    alu_or,
    alu_xor,
    alu_sll,
    alu_srl,
    alu_sra,
    alu_slt,
    alu_sltu
  } alu_op_t;

  // branch conditions, funct3 field
  localparam logic [2:0] f3_beq  = 3'b000;
  localparam logic [2:0] f3_bne  = 3'b001;
  localparam logic [2:0] f3_blt  = 3'b100;
  localparam logic [2:0] f3_bge  = 3'b101;
  localparam logic [2:0] f3_bltu = 3'b110;
  localparam logic [2:0] f3_bgeu = 3'b111;

endpackage

// File: source/riscv_system.sv
`timescale 1ns/1ns

module riscv_system (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 host_we,
  input  riscv_isa_pkg::word_t host_addr,
  input  riscv_isa_pkg::word_t host_wdata,
  output riscv_isa_pkg::word_t host_rdata,
  output logic                 halt,
  output riscv_isa_pkg::word_t trace_writeback_pc,
  output riscv_isa_pkg::word_t trace_writeback_inst
);

  import riscv_isa_pkg::*;
  import pipeline_pkg::*;

  word_t       pc;
  word_t       inst;
  word_t       redirect_pc;
  word_t       wb_data;
  word_t       dmem_rdata;
  logic        stall;
  logic        redirect;
  fd_payload_t fd;
  de_payload_t de_next;
  de_payload_t de;
  em_payload_t em_next;
  em_payload_t em;
  mw_payload_t mw_next;
  mw_payload_t mw;

  fetch_unit i_fetch_unit (
    .clk         (clk),
    .rst         (rst),
    .stall       (stall),
    .halt        (halt),
    .redirect    (redirect),
    .redirect_pc (redirect_pc),
    .pc          (pc)
  );

  stage_reg #(.payload_t(fd_payload_t), .bubble(fd_bubble)) i_fd_reg (
    .clk   (clk),
    .rst   (rst),
    .hold  (stall || halt),
    .flush (redirect),
    .d     ('{pc: pc, inst: inst}),
    .q     (fd)
  );

  decode_unit i_decode_unit (
    .clk     (clk),
    .rst     (rst),
    .fd      (fd),
    .de_q    (de),
    .mw      (mw),
    .de_next (de_next),
    .stall   (stall),
    .wb_data (wb_data)
  );

  // later stages freeze on halt so the ECALL stays in writeback
  stage_reg #(.payload_t(de_payload_t), .bubble(de_bubble)) i_de_reg (
    .clk   (clk),
    .rst   (rst),
    .hold  (halt),
    .flush (stall || redirect),
    .d     (de_next),
    .q     (de)
  );

  execute_unit i_execute_unit (
    .de          (de),
    .em          (em),
    .mw          (mw),
    .wb_data     (wb_data),
    .em_next     (em_next),
    .redirect    (redirect),
    .redirect_pc (redirect_pc)
  );

  stage_reg #(.payload_t(em_payload_t), .bubble(em_bubble)) i_em_reg (
    .clk   (clk),
    .rst   (rst),
    .hold  (halt),
    .flush (1'b0),
    .d     (em_next),
    .q     (em)
  );

  unified_memory i_unified_memory (
    .clk        (clk),
    .rst        (rst),
    .imem_addr  (pc),
    .imem_data  (inst),
    .dmem_addr  (em.alu_result),
    .dmem_wdata (em.store_data),
    .dmem_we    (em.mem_write),
    .dmem_rdata (dmem_rdata),
    .host_we    (host_we),
    .host_addr  (host_addr),
    .host_wdata (host_wdata),
    .host_rdata (host_rdata)
  );

  assign mw_next = '{
    pc:         em.pc,
    inst:       em.inst,
    alu_result: em.alu_result,
    load_data:  dmem_rdata,
    rd:         em.rd,
    reg_write:  em.reg_write,
    mem_read:   em.mem_read,
    halt:       em.halt
  };

  stage_reg #(.payload_t(mw_payload_t), .bubble(mw_bubble)) i_mw_reg (
    .clk   (clk),
    .rst   (rst),
    .hold  (halt),
    .flush (1'b0),
    .d     (mw_next),
    .q     (mw)
  );

  assign halt                 = mw.halt;
  assign trace_writeback_pc   = mw.pc;
  assign trace_writeback_inst = mw.inst;

endmodule

// File: source/stage_reg.sv
`timescale 1ns/1ns

module stage_reg #(
  parameter type payload_t = logic,
  parameter payload_t bubble = '0
) (
  input  logic     clk,
  input  logic     rst,
  input  logic     hold,
  input  logic     flush,
  input  payload_t d,
  output payload_t q
);

  // flush beats hold, so a squashed slot never lingers
  always_ff @(posedge clk) begin
    if (rst || flush) begin
      q <= bubble;
    end else if (!hold) begin
      q <= d;
    end
  end

endmodule

// File: source/unified_memory.sv
`timescale 1ns/1ns
`include "riscv_config.svh"

module unified_memory (
  input  logic                 clk,
  input  logic                 rst,
  input  riscv_isa_pkg::word_t imem_addr,
  output riscv_isa_pkg::word_t imem_data,
  input  riscv_isa_pkg::word_t dmem_addr,
  input  riscv_isa_pkg::word_t dmem_wdata,
  input  logic                 dmem_we,
  output riscv_isa_pkg::word_t dmem_rdata,
  input  logic                 host_we,
  input  riscv_isa_pkg::word_t host_addr,
  input  riscv_isa_pkg::word_t host_wdata,
  output riscv_isa_pkg::word_t host_rdata
);

  import riscv_isa_pkg::*;

  localparam int unsigned idx_bits = $clog2(`RV_MEM_WORDS);

  word_t               mem [`RV_MEM_WORDS];
  logic [idx_bits-1:0] wr_idx;
  logic                wr_en;
  word_t               wr_data;

  // host owns the write port while the core sits in reset
  assign wr_idx  = rst ? host_addr[idx_bits+1:2] : dmem_addr[idx_bits+1:2];
  assign wr_en   = rst ? host_we : dmem_we;
  assign wr_data = rst ? host_wdata : dmem_wdata;

  // falling edge gives data half a cycle before the next rising edge
  always_ff @(negedge clk) begin
    imem_data  <= mem[imem_addr[idx_bits+1:2]];
    dmem_rdata <= mem[dmem_addr[idx_bits+1:2]];
    host_rdata <= mem[host_addr[idx_bits+1:2]];
    if (wr_en) begin
      mem[wr_idx] <= wr_data;
    end
  end

endmodule

// File: sources.f
+incdir+source
source/riscv_isa_pkg.sv
source/pipeline_pkg.sv
source/stage_reg.sv
source/reg_file.sv
source/decode_unit.sv
source/execute_unit.sv
source/fetch_unit.sv
source/unified_memory.sv
source/riscv_system.sv
testbench/riscv_system_checker.sv
testbench/riscv_system_tb.sv

// File: testbench/riscv_system_checker.sv
`timescale 1ns/1ns
`include "riscv_config.svh"

module riscv_system_checker (
  input logic                 clk,
  input logic                 rst,
  input logic                 halt,
  input riscv_isa_pkg::word_t trace_writeback_pc,
  input riscv_isa_pkg::word_t trace_writeback_inst
);

  int failures = 0;

  // reset leaves a bubble in writeback
  halt_low_after_reset: assert property (@(posedge clk) rst |=> !halt)
    else begin
      failures++;
      $error("halt high in the cycle after reset");
    end

  // pc and upper stages freeze, so halt only drops through reset
  halt_sticky: assert property (@(posedge clk) disable iff (rst) halt |=> halt)
    else begin
      failures++;
      $error("halt dropped without reset");
    end

  bubble_trace: assert property (@(posedge clk) disable iff (rst)
                                 (trace_writeback_pc == '0) |-> (trace_writeback_inst == `RV_NOP))
    else begin
      failures++;
      $error("trace pc 0 without a nop");
    end

endmodule

bind riscv_system riscv_system_checker i_riscv_system_checker (
  .clk                  (clk),
  .rst                  (rst),
  .halt                 (halt),
  .trace_writeback_pc   (trace_writeback_pc),
  .trace_writeback_inst (trace_writeback_inst)
);

// File: testbench/riscv_system_tb.sv
`timescale 1ns/1ns
`include "riscv_config.svh"

module riscv_system_tb;

  import riscv_isa_pkg::*;

  localparam int    num_tests       = 6;
  localparam int    cycles_per_test = 300;
  localparam word_t data_base       = 32'h0000_0200;
  localparam word_t ecall_word      = 32'h0000_0073;
  localparam int    opc_imm         = 7'h13;
  localparam int    opc_lui         = 7'h37;
  localparam int    opc_auipc       = 7'h17;
  localparam int    opc_jalr        = 7'h67;
  localparam int    opc_load        = 7'h03;

  logic  clk;
  logic  rst;
  logic  host_we;
  word_t host_addr;
  word_t host_wdata;
  word_t host_rdata;
  logic  halt;
  word_t trace_writeback_pc;
  word_t trace_writeback_inst;

  word_t prog [$];
  word_t expected_words [$];
  word_t squashed_pcs [$];
  int    checks;
  int    errors;
  int    failed_tests;

  riscv_system i_riscv_system (
    .clk                  (clk),
    .rst                  (rst),
    .host_we              (host_we),
    .host_addr            (host_addr),
    .host_wdata           (host_wdata),
    .host_rdata           (host_rdata),
    .halt                 (halt),
    .trace_writeback_pc   (trace_writeback_pc),
    .trace_writeback_inst (trace_writeback_inst)
  );

  always #2 clk = ~clk;

  // bound to the combined length of all tests
  initial begin
    repeat (num_tests * cycles_per_test) @(posedge clk);
    $display("run timed out after %0d cycles, a program never halted",
             num_tests * cycles_per_test);
    $display("*** FAILED ***");
    $finish;
  end

  // instruction encoders
  function automatic word_t r_type(input int f7, input int rs2, input int rs1, input int f3,
                                   input int rd);
    return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'b0110011};
  endfunction

  function automatic word_t i_type(input int imm, input int rs1, input int f3, input int rd,
                                   input int opc);
    return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], opc[6:0]};
  endfunction

  function automatic word_t s_type(input int imm, input int rs2, input int rs1);
    return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], 7'b0100011};
  endfunction

  function automatic word_t b_type(input int imm, input int rs2, input int rs1, input int f3);
    return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11], 7'b1100011};
  endfunction

  function automatic word_t j_type(input int imm, input int rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], 7'b1101111};
  endfunction

  function automatic word_t u_type(input int imm, input int rd, input int opc);
    return {imm[19:0], rd[4:0], opc[6:0]};
  endfunction

  function automatic word_t next_pc();
    return word_t'(4 * prog.size());
  endfunction

  function automatic bit is_squashed(input word_t pc);
    foreach (squashed_pcs[i]) begin
      if (squashed_pcs[i] == pc) begin
        return 1'b1;
      end
    end
    return 1'b0;
  endfunction

  function void emit(input word_t inst);
    prog.push_back(inst);
  endfunction

  task automatic compare(input word_t actual, input word_t expected, input string what);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("[ERROR] %0t ns: %s: got %h, expected %h", $time, what, actual, expected);
    end
  endtask

  task automatic start_program();
    prog.delete();
    expected_words.delete();
    squashed_pcs.delete();
    // address 0 holds a nop, so pc 0 in the trace always reads as a bubble
    prog.push_back(`RV_NOP);
  endtask

  // next free data slot gets the register, and the test records what it must hold
  task automatic store_result(input int rs2, input word_t value);
    emit(s_type(data_base + 4 * expected_words.size(), rs2, 0));
    expected_words.push_back(value);
  endtask

  task automatic marker_store();
    squashed_pcs.push_back(next_pc());
    store_result(31, '0);
  endtask

  task automatic word_from_slot(input int rd, input int slot);
    emit(i_type(data_base + 4 * slot, 0, 2, rd, opc_load));
  endtask

  task automatic const_to_reg(input int rd, input word_t value);
    word_t upper;
    // addi sign-extends its immediate, so round the upper part up when bit 11 is set
    upper = (value + 32'h800) >> 12;
    emit(u_type(upper, rd, opc_lui));
    emit(i_type(value[11:0], rd, 0, rd, opc_imm));
  endtask

  task automatic host_write(input word_t addr, input word_t data);
    host_we    <= 1'b1;
    host_addr  <= addr;
    host_wdata <= data;
    @(posedge clk);
  endtask

  // memory keeps its contents over reset, so result slots are cleared first
  task automatic write_image();
    foreach (expected_words[i]) begin
      host_write(word_t'(data_base + 4 * i), '0);
    end
    foreach (prog[i]) begin
      host_write(word_t'(4 * i), prog[i]);
    end
    repeat (4) begin
      host_write(word_t'(4 * prog.size()), `RV_NOP);
      prog.push_back(`RV_NOP);
    end
    host_we <= 1'b0;
  endtask

  task automatic run_test(input string name, input int hold_cycles);
    int    errors_before;
    word_t ecall_pc;
    errors_before = errors;
    ecall_pc = next_pc();
    emit(ecall_word);
    write_image();
    rst <= 1'b0;
    @(posedge clk);
    while (!halt) begin
      compare(word_t'(is_squashed(trace_writeback_pc)), '0,
              $sformatf("%s: squashed pc %h in writeback", name, trace_writeback_pc));
      @(posedge clk);
    end
    repeat (hold_cycles) begin
      compare(word_t'(halt), 32'd1, $sformatf("%s: halt level", name));
      compare(trace_writeback_pc, ecall_pc, $sformatf("%s: trace pc while halted", name));
      compare(trace_writeback_inst, ecall_word, $sformatf("%s: trace inst", name));
      @(posedge clk);
    end
    rst <= 1'b1;
    @(posedge clk);
    foreach (expected_words[i]) begin
      host_addr <= word_t'(data_base + 4 * i);
      @(posedge clk);
      compare(host_rdata, expected_words[i], $sformatf("%s: data word %0d", name, i));
    end
    if (errors == errors_before) begin
      $display("test %s: ok", name);
    end else begin
      failed_tests++;
      $display("test %s: %0d errors", name, errors - errors_before);
    end
  endtask

  task automatic alu_case(input word_t inst, input word_t value);
    emit(inst);
    store_result(5, value);
  endtask

  task automatic alu_ops();
    word_t a;
    word_t b;
    word_t c;
    a = 32'h8765_4321;
    b = 32'd19;
    c = 32'hffff_fffb;
    start_program();
    const_to_reg(1, a);
    const_to_reg(2, b);
    emit(i_type(-5, 0, 0, 3, opc_imm));
    alu_case(r_type(0, 2, 1, 0, 5), a + b);
    alu_case(r_type(32, 2, 1, 0, 5), a - b);
    alu_case(r_type(0, 2, 1, 7, 5), a & b);
    alu_case(r_type(0, 2, 1, 6, 5), a | b);
    alu_case(r_type(0, 2, 1, 4, 5), a ^ b);
    alu_case(r_type(0, 2, 1, 1, 5), a << b[4:0]);
    alu_case(r_type(0, 2, 1, 5, 5), a >> b[4:0]);
    alu_case(r_type(32, 2, 1, 5, 5), word_t'($signed(a) >>> b[4:0]));
    alu_case(r_type(0, 2, 1, 2, 5), word_t'($signed(a) < $signed(b)));
    alu_case(r_type(0, 2, 1, 3, 5), word_t'(a < b));
    alu_case(i_type(-100, 1, 0, 5, opc_imm), a - 32'd100);
    alu_case(i_type(12'h0f0, 1, 7, 5, opc_imm), a & 32'h0000_00f0);
    alu_case(i_type(12'h7ff, 1, 6, 5, opc_imm), a | 32'h0000_07ff);
    alu_case(i_type(-1, 1, 4, 5, opc_imm), ~a);
    alu_case(i_type(7, 1, 1, 5, opc_imm), a << 7);
    alu_case(i_type(9, 1, 5, 5, opc_imm), a >> 9);
    // bit 30 of the immediate selects the arithmetic shift
    alu_case(i_type(12'h409, 1, 5, 5, opc_imm), word_t'($signed(a) >>> 9));
    alu_case(i_type(-4, 3, 2, 5, opc_imm), word_t'($signed(c) < -4));
    alu_case(i_type(-1, 1, 3, 5, opc_imm), word_t'(a < 32'hffff_ffff));
    run_test("alu ops", 4);
  endtask

  task automatic forwarding_paths();
    start_program();
    emit(i_type(5, 0, 0, 1, opc_imm));
    emit(i_type(7, 1, 0, 2, opc_imm));
    // x2 comes from M, x1 from W
    emit(r_type(0, 1, 2, 0, 3));
    emit(r_type(0, 3, 3, 0, 4));
    emit(i_type(3, 0, 0, 6, opc_imm));
    emit(i_type(4, 0, 0, 7, opc_imm));
    emit(i_type(9, 0, 0, 8, opc_imm));
    // x6 through the decode bypass, x7 from W
    emit(r_type(0, 7, 6, 0, 9));
    emit(r_type(0, 8, 9, 0, 10));
    store_result(10, 3 + 4 + 9);
    store_result(9, 3 + 4);
    store_result(4, 2 * (5 + 7 + 5));
    store_result(3, 5 + 7 + 5);
    store_result(2, 5 + 7);
    run_test("forwarding", 4);
  endtask

  task automatic load_use();
    word_t v;
    v = 32'h1234_5678;
    start_program();
    const_to_reg(1, v);
    store_result(1, v);
    word_from_slot(2, 0);
    emit(r_type(0, 2, 2, 0, 3));
    store_result(3, v + v);
    // store data straight from a load
    word_from_slot(4, 0);
    store_result(4, v);
    word_from_slot(5, 1);
    emit(i_type(1, 5, 0, 6, opc_imm));
    store_result(6, v + v + 1);
    run_test("load use", 4);
  endtask

  task automatic branch_case(input int f3, input int rs1, input int rs2, input bit taken);
    if (taken) begin
      emit(b_type(12, rs2, rs1, f3));
      marker_store();
      marker_store();
    end else begin
      emit(b_type(8, rs2, rs1, f3));
      store_result(30, 32'd1);
    end
  endtask

  task automatic branches_and_jumps();
    word_t pc_jump;
    start_program();
    emit(i_type(5, 0, 0, 1, opc_imm));
    emit(i_type(-3, 0, 0, 2, opc_imm));
    emit(i_type(5, 0, 0, 3, opc_imm));
    emit(i_type(1, 0, 0, 30, opc_imm));
    const_to_reg(31, 32'hbad0_0bad);
    // x1 = 5, x2 = -3, x3 = 5
    branch_case(0, 1, 3, 1'b1);
    branch_case(0, 1, 2, 1'b0);
    branch_case(1, 1, 2, 1'b1);
    branch_case(1, 1, 3, 1'b0);
    branch_case(4, 2, 1, 1'b1);
    branch_case(4, 1, 2, 1'b0);
    branch_case(5, 1, 2, 1'b1);
    branch_case(5, 2, 1, 1'b0);
    branch_case(6, 1, 2, 1'b1);
    branch_case(6, 2, 1, 1'b0);
    branch_case(7, 2, 1, 1'b1);
    branch_case(7, 1, 2, 1'b0);
    pc_jump = next_pc();
    emit(j_type(12, 20));
    marker_store();
    marker_store();
    store_result(20, pc_jump + 4);
    // target four words ahead, bit 0 set so the jump has to clear it
    emit(i_type(next_pc() + 17, 0, 0, 21, opc_imm));
    pc_jump = next_pc();
    emit(i_type(0, 21, 0, 22, opc_jalr));
    marker_store();
    marker_store();
    store_result(22, pc_jump + 4);
    run_test("branches and jumps", 4);
  endtask

  task automatic upper_imm_and_x0();
    word_t pc_auipc;
    start_program();
    emit(u_type(32'habcde, 1, opc_lui));
    store_result(1, 32'habcd_e000);
    pc_auipc = next_pc();
    emit(u_type(32'h12345, 2, opc_auipc));
    store_result(2, pc_auipc + 32'h1234_5000);
    pc_auipc = next_pc();
    emit(u_type(32'hfffff, 3, opc_auipc));
    store_result(3, pc_auipc - 32'h0000_1000);
    emit(i_type(1, 0, 0, 5, opc_imm));
    emit(i_type(76, 5, 0, 0, opc_imm));
    // x0 read while the dropped write sits in M, then in W
    emit(r_type(0, 5, 0, 0, 6));
    emit(r_type(0, 5, 0, 0, 7));
    emit(u_type(32'h12345, 0, opc_lui));
    emit(i_type(2, 0, 0, 9, opc_imm));
    emit(r_type(0, 5, 0, 0, 8));
    store_result(6, 32'd1);
    store_result(7, 32'd1);
    store_result(8, 32'd1);
    store_result(9, 32'd2);
    run_test("upper immediates and x0", 4);
  endtask

  task automatic halt_hold();
    start_program();
    emit(i_type(42, 0, 0, 1, opc_imm));
    store_result(1, 32'd42);
    run_test("halt", 40);
  endtask

  initial begin
    int total_errors;
    clk          = 1'b0;
    rst          = 1'b1;
    host_we      = 1'b0;
    host_addr    = '0;
    host_wdata   = '0;
    checks       = 0;
    errors       = 0;
    failed_tests = 0;
    repeat (2) @(posedge clk);
    alu_ops();
    forwarding_paths();
    load_use();
    branches_and_jumps();
    upper_imm_and_x0();
    halt_hold();
    total_errors = errors + i_riscv_system.i_riscv_system_checker.failures;
    $display("%0d tests, %0d failed, %0d checks, %0d errors, %0d assertion failures",
             num_tests, failed_tests, checks, errors,
             i_riscv_system.i_riscv_system_checker.failures);
    if (total_errors == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule
